//--- filelist.f
source/ramDmaPkg.sv
source/dualPortSsram.sv
source/dmaBusMaster.sv
source/dmaController.sv
source/ramDmaCi.sv
verif/busSlaveModel.sv
verif/ramDmaCiTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Builds the DMA testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ramDmaCiTb \
    --Mdir obj_dir -o ramDmaCiTbSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/ramDmaCiTbSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0

//--- verif/ramDmaCiTb.sv
/*
 * Testbench for the custom-instruction DMA block.
 * Drives CPU instructions, runs DMA transfers against a behavioral
 * bus slave and checks SRAM, registers, status and bus bursts.
 */
`timescale 1ns/10ps

module ramDmaCiTb;

    localparam int watchdogCycles = (23 + 37 + 30 + 4) * 20 + 3000;

    logic clock;
    logic reset;
    ramDmaPkg::ciRequest ci;
    logic done;
    logic [31:0] result;
    ramDmaPkg::busToMaster busIn;
    ramDmaPkg::masterToBus busOut;
    logic busyEnable;
    int errorAt;
    int beatsRead;
    int beatsWritten;
    int errorCount = 0;

    logic [31:0] seed = 32'd73;
    logic [31:0] sramModel [0:511];
    bit known [0:511];
    logic [31:0] expAddr [$];
    logic [7:0] expCode [$];
    logic expRead;
    logic checkBegins = 1'b0;

    ramDmaCi dut (
        .clock (clock),
        .reset (reset),
        .ci    (ci),
        .done  (done),
        .result(result),
        .busIn (busIn),
        .busOut(busOut)
    );

    busSlaveModel slave (
        .clock       (clock),
        .reset       (reset),
        .busIn       (busOut),
        .busOut      (busIn),
        .busyEnable  (busyEnable),
        .errorAt     (errorAt),
        .beatsRead   (beatsRead),
        .beatsWritten(beatsWritten)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic failNow(input string what);
        errorCount++;
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected)
        else failNow($sformatf("[FAIL] %s expected %h got %h", name, expected, actual));
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] makeA(input logic [2:0] sel, input logic write,
                                          input logic [8:0] addr);
        return {19'd0, sel, write, addr};
    endfunction

    task automatic issue(input logic start, input logic [7:0] n, input logic [31:0] a,
                         input logic [31:0] b);
        @(posedge clock);
        #2;
        ci.start = start;
        ci.ciN = n;
        ci.valueA = a;
        ci.valueB = b;
    endtask

    task automatic writeWord(input logic [31:0] a, input logic [31:0] b);
        issue(1'b1, ramDmaPkg::customId, a, b);
        #1;
        assert (done === 1'b1) else failNow("write instruction gave no done in its cycle");
        @(posedge clock);
        #2;
        ci.start = 1'b0;
    endtask

    task automatic readWord(input logic [31:0] a, output logic [31:0] data);
        issue(1'b1, ramDmaPkg::customId, a, 32'd0);
        #1;
        assert (done === 1'b0) else failNow("read instruction gave done too early");
        @(posedge clock);
        #2;
        ci.start = 1'b0;
        #1;
        assert (done === 1'b1) else failNow("read instruction gave no done one cycle later");
        data = result;
    endtask

    // Instruction that must be ignored
    task automatic ignored(input logic start, input logic [7:0] n, input logic [31:0] a,
                           input logic [31:0] b);
        issue(start, n, a, b);
        #1;
        assert (done === 1'b0) else failNow("ignored instruction gave done");
        @(posedge clock);
        #2;
        ci.start = 1'b0;
        #1;
        assert (done === 1'b0) else failNow("ignored instruction gave a late done");
    endtask

    task automatic waitIdle(output logic [31:0] status);
        do begin
            readWord(makeA(3'd5, 1'b0, 9'd0), status);
        end while (status[0]);
    endtask

    task automatic setup(input logic [31:0] bus, input logic [8:0] mem,
                         input logic [9:0] block, input logic [7:0] code);
        writeWord(makeA(3'd1, 1'b1, 9'd0), bus);
        writeWord(makeA(3'd2, 1'b1, 9'd0), {23'd0, mem});
        writeWord(makeA(3'd3, 1'b1, 9'd0), {22'd0, block});
        writeWord(makeA(3'd4, 1'b1, 9'd0), {24'd0, code});
    endtask

    task automatic planBursts(input logic [31:0] bus, input int block, input int code,
                              input logic isRead);
        int left;
        int len;
        left = block;
        expRead = isRead;
        while (left > 0) begin
            len = (left < code + 1) ? left : code + 1;
            expAddr.push_back(bus);
            expCode.push_back(8'(len - 1));
            bus = bus + 32'(4 * len);
            left = left - len;
        end
    endtask

    // Each burst start is compared with the expected split
    always @(negedge clock) begin
        if (checkBegins && busOut.beginTransaction) begin
            assert (expAddr.size() > 0) else failNow("unexpected bus begin transaction");
            checkValue("busOut.addressData", expAddr.pop_front(), busOut.addressData);
            checkValue("busOut.burstSize", {24'd0, expCode.pop_front()},
                       {24'd0, busOut.burstSize});
            checkValue("busOut.readNotWrite", {31'd0, expRead}, {31'd0, busOut.readNotWrite});
            checkValue("busOut.byteEnable", 32'hF, {28'd0, busOut.byteEnable});
        end
    end

    initial begin
        #(watchdogCycles * 40);
        failNow("watchdog timeout, the run did not finish in time");
    end

    initial begin
        logic [31:0] data;
        logic [31:0] regValue [1:4];
        logic [31:0] masks [1:4];
        logic [31:0] slaveRef [0:63];
        logic [8:0] addr;
        int writtenBefore;

        masks[1] = 32'hFFFFFFFF;
        masks[2] = 32'h000001FF;
        masks[3] = 32'h000003FF;
        masks[4] = 32'h000000FF;
        ci = '0;
        busyEnable = 1'b0;
        errorAt = 0;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        // CPU SRAM writes and reads at random addresses
        for (int i = 0; i < 16; i++) begin
            seed = lcgNext(seed);
            addr = seed[24:16];
            seed = lcgNext(seed);
            writeWord(makeA(3'd0, 1'b1, addr), seed);
            sramModel[addr] = seed;
            known[addr] = 1'b1;
        end
        for (int i = 0; i < 512; i++) begin
            if (known[i]) begin
                readWord(makeA(3'd0, 1'b0, 9'(i)), data);
                checkValue("result", sramModel[i], data);
            end
        end

        // Register readback masked to width
        for (int r = 1; r <= 4; r++) begin
            seed = lcgNext(seed);
            writeWord(makeA(3'(r), 1'b1, 9'd0), seed);
            regValue[r] = seed & masks[r];
            readWord(makeA(3'(r), 1'b0, 9'd0), data);
            checkValue("result", regValue[r], data);
        end
        readWord(makeA(3'd5, 1'b0, 9'd0), data);
        checkValue("status", 32'd0, data);

        // Ignored instructions change nothing
        seed = lcgNext(seed);
        writeWord(makeA(3'd0, 1'b1, 9'd7), seed);
        sramModel[7] = seed;
        ignored(1'b0, ramDmaPkg::customId, makeA(3'd3, 1'b1, 9'd0), 32'h155);
        ignored(1'b1, 8'h0E, makeA(3'd3, 1'b1, 9'd0), 32'h2AA);
        ignored(1'b1, 8'h0E, makeA(3'd0, 1'b1, 9'd7), 32'hDEADBEEF);
        ignored(1'b0, ramDmaPkg::customId, makeA(3'd0, 1'b1, 9'd7), 32'hDEADBEEF);
        readWord(makeA(3'd3, 1'b0, 9'd0), data);
        checkValue("blockSize", regValue[3], data);
        readWord(makeA(3'd0, 1'b0, 9'd7), data);
        checkValue("sram[7]", sramModel[7], data);

        // Bus to SRAM transfer of 23 words in bursts of 8
        for (int i = 0; i < 23; i++) begin
            slaveRef[i] = slave.memory[64 + i];
        end
        planBursts(32'h100, 23, 7, 1'b1);
        checkBegins = 1'b1;
        setup(32'h100, 9'd40, 10'd23, 8'd7);
        writeWord(makeA(3'd5, 1'b1, 9'd0), 32'd1);
        waitIdle(data);
        checkValue("status", 32'd0, data);
        assert (expAddr.size() == 0) else failNow("bus read transfer ran too few bursts");
        for (int i = 0; i < 23; i++) begin
            readWord(makeA(3'd0, 1'b0, 9'(40 + i)), data);
            checkValue("sram read data", slaveRef[i], data);
        end

        // SRAM to bus transfer of 37 words in bursts of 5 under busy
        for (int i = 0; i < 37; i++) begin
            seed = lcgNext(seed);
            writeWord(makeA(3'd0, 1'b1, 9'(100 + i)), seed);
            sramModel[100 + i] = seed;
        end
        slaveRef[0] = slave.memory[511];
        slaveRef[1] = slave.memory[549];
        writtenBefore = beatsWritten;
        busyEnable = 1'b1;
        planBursts(32'h800, 37, 4, 1'b0);
        setup(32'h800, 9'd100, 10'd37, 8'd4);
        writeWord(makeA(3'd5, 1'b1, 9'd0), 32'd2);
        waitIdle(data);
        checkValue("status", 32'd0, data);
        assert (expAddr.size() == 0) else failNow("bus write transfer ran too few bursts");
        checkValue("beatsWritten", 32'd37, 32'(beatsWritten - writtenBefore));
        for (int i = 0; i < 37; i++) begin
            checkValue("slave memory", sramModel[100 + i], slave.memory[512 + i]);
        end
        checkValue("slave memory[511]", slaveRef[0], slave.memory[511]);
        checkValue("slave memory[549]", slaveRef[1], slave.memory[549]);
        busyEnable = 1'b0;

        // Error mid transfer and a fresh launch that clears it
        checkBegins = 1'b0;
        errorAt = beatsRead + 10;
        setup(32'h200, 9'd300, 10'd30, 8'd7);
        writeWord(makeA(3'd5, 1'b1, 9'd0), 32'd1);
        waitIdle(data);
        checkValue("status", 32'd2, data);
        errorAt = 0;
        setup(32'h40, 9'd200, 10'd4, 8'd7);
        writeWord(makeA(3'd5, 1'b1, 9'd0), 32'd1);
        readWord(makeA(3'd5, 1'b0, 9'd0), data);
        checkValue("status error bit", 32'd0, {31'd0, data[1]});
        waitIdle(data);
        checkValue("status", 32'd0, data);

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/busSlaveModel.sv
/*
 * Behavioral system bus slave for the DMA testbench.
 * Grants the bus a few cycles after request, serves read and write
 * bursts from its own word memory, raises busy in a pseudo-random
 * pattern and can flag an error on a chosen read beat.
 */
`timescale 1ns/10ps

module busSlaveModel (
    input  logic                  clock,
    input  logic                  reset,
    input  ramDmaPkg::masterToBus busIn,
    output ramDmaPkg::busToMaster busOut,
    input  logic                  busyEnable,
    input  int                    errorAt,
    output int                    beatsRead,
    output int                    beatsWritten
);

    typedef enum logic [2:0] {
        slaveIdle, grantWait, beginWait, readBurst, writeBurst, releaseBus
    } slaveState;

    slaveState state;
    logic [31:0] memory [0:1023];
    logic [31:0] seed;
    logic [9:0] index;
    logic busyPrev;
    int delay;
    int beat;
    int burstBeats;

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Fill word mixes every address bit
    initial begin
        for (int i = 0; i < 1024; i++) begin
            memory[i] <= 32'h5A000000 ^ (i * 32'h01000193) ^ i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= slaveIdle;
            busOut <= '0;
            seed <= 32'd73;
            busyPrev <= 1'b0;
            beatsRead <= 0;
            beatsWritten <= 0;
        end else begin
            seed <= nextRandom(seed);
            busOut.grant <= 1'b0;
            busOut.dataValid <= 1'b0;
            busOut.endTransaction <= 1'b0;
            busOut.error <= 1'b0;
            busOut.busy <= busyEnable && (seed[17:16] == 2'b00);
            // Master sees busy one cycle late
            busyPrev <= busOut.busy;
            case (state)
                slaveIdle: begin
                    if (busIn.request) begin
                        delay <= int'(seed[25:24]) % 3;
                        state <= grantWait;
                    end
                end
                grantWait: begin
                    if (delay == 0) begin
                        busOut.grant <= 1'b1;
                        state <= beginWait;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                beginWait: begin
                    if (busIn.beginTransaction) begin
                        index <= busIn.addressData[11:2];
                        burstBeats <= int'(busIn.burstSize) + 1;
                        beat <= 0;
                        state <= busIn.readNotWrite ? readBurst : writeBurst;
                    end
                end
                readBurst: begin
                    if (beat < burstBeats) begin
                        busOut.dataValid <= 1'b1;
                        busOut.addressData <= memory[index];
                        index <= index + 1'b1;
                        beat <= beat + 1;
                        beatsRead <= beatsRead + 1;
                        if (errorAt != 0 && beatsRead + 1 == errorAt) begin
                            busOut.error <= 1'b1;
                        end
                    end else begin
                        busOut.endTransaction <= 1'b1;
                        state <= releaseBus;
                    end
                end
                writeBurst: begin
                    if (busIn.dataValid && !busyPrev) begin
                        memory[index] <= busIn.addressData;
                        index <= index + 1'b1;
                        beatsWritten <= beatsWritten + 1;
                    end
                    if (busIn.endTransaction) begin
                        state <= releaseBus;
                    end
                end
                // Wait for request to drop before the next arbitration
                default: begin
                    if (!busIn.request) begin
                        state <= slaveIdle;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/ramDmaCi.sv
/*
 * Custom-instruction DMA block, top level.
 * Decodes CPU custom instructions into local SRAM accesses and DMA
 * register accesses, answers with done and result, and registers
 * every system bus input once before the DMA engine sees it.
 */
`timescale 1ns/10ps

module ramDmaCi (
    input  logic                  clock,
    input  logic                  reset,
    input  ramDmaPkg::ciRequest   ci,
    output logic                  done,
    output logic [31:0]           result,
    input  ramDmaPkg::busToMaster busIn,
    output ramDmaPkg::masterToBus busOut
);

    ramDmaPkg::regSelect select;
    ramDmaPkg::regSelect selectReg;
    ramDmaPkg::busToMaster busInReg;
    logic matched;
    logic isWrite;
    logic legal;
    logic legalReg;
    logic readPending;
    logic sramWriteA;
    logic regWrite;
    logic [31:0] sramDataA;
    logic [31:0] regReadData;
    logic [ramDmaPkg::sramAddrWidth-1:0] sramAddressB;
    logic sramWriteEnableB;
    logic [31:0] sramWriteDataB;
    logic [31:0] sramReadDataB;

    assign matched = ci.start && (ci.ciN == ramDmaPkg::customId);
    assign isWrite = ci.valueA[9];
    assign select = ramDmaPkg::regSelect'(ci.valueA[12:10]);

    // Upper bits must be clear and the select within range
    assign legal = (ci.valueA[31:13] == '0) && (ci.valueA[12:10] <= 3'd5);

    assign sramWriteA = matched && isWrite && legal && (select == ramDmaPkg::sramAccess);
    assign regWrite = matched && isWrite && legal && (select != ramDmaPkg::sramAccess);

    always_ff @(posedge clock) begin
        if (reset) begin
            readPending <= 1'b0;
        end else begin
            readPending <= matched && !isWrite;
        end
    end

    always_ff @(posedge clock) begin
        selectReg <= select;
        legalReg <= legal;
    end

    // Writes finish at once, reads one cycle later
    assign done = (matched && isWrite) || readPending;

    always_comb begin
        result = 32'd0;
        if (readPending && legalReg) begin
            result = (selectReg == ramDmaPkg::sramAccess) ? sramDataA : regReadData;
        end
    end

    // One register stage on all bus inputs
    always_ff @(posedge clock) begin
        if (reset) begin
            busInReg <= '0;
        end else begin
            busInReg <= busIn;
        end
    end

    dualPortSsram sram (
        .clock       (clock),
        .addressA    (ci.valueA[ramDmaPkg::sramAddrWidth-1:0]),
        .addressB    (sramAddressB),
        .writeEnableA(sramWriteA),
        .writeEnableB(sramWriteEnableB),
        .dataInA     (ci.valueB),
        .dataInB     (sramWriteDataB),
        .dataOutA    (sramDataA),
        .dataOutB    (sramReadDataB)
    );

    dmaController controller (
        .clock          (clock),
        .reset          (reset),
        .regWrite       (regWrite),
        .regSelect      (select),
        .writeData      (ci.valueB),
        .readData       (regReadData),
        .busIn          (busInReg),
        .busOut         (busOut),
        .sramAddress    (sramAddressB),
        .sramWriteEnable(sramWriteEnableB),
        .sramWriteData  (sramWriteDataB),
        .sramReadData   (sramReadDataB)
    );

endmodule

//--- source/dmaController.sv
/*
 * DMA configuration and status registers.
 * Holds the transfer setup written by the CPU, turns a control write
 * into a launch pulse when idle, keeps the sticky error flag and
 * returns the selected register one cycle after the request.
 */
`timescale 1ns/10ps

module dmaController (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                regWrite,
    input  ramDmaPkg::regSelect                 regSelect,
    input  logic [31:0]                         writeData,
    output logic [31:0]                         readData,
    input  ramDmaPkg::busToMaster               busIn,
    output ramDmaPkg::masterToBus               busOut,
    output logic [ramDmaPkg::sramAddrWidth-1:0] sramAddress,
    output logic                                sramWriteEnable,
    output logic [31:0]                         sramWriteData,
    input  logic [31:0]                         sramReadData
);

    ramDmaPkg::dmaConfig setup;
    logic launch;
    logic launchRequest;
    logic running;
    logic errorPulse;
    logic errorSticky;

    // Launch only from idle, and only with a direction bit set
    assign launchRequest = regWrite && (regSelect == ramDmaPkg::controlStatus)
                           && (writeData[1:0] != 2'b00) && !running && !launch;

    always_ff @(posedge clock) begin
        if (reset) begin
            setup <= '0;
            launch <= 1'b0;
            errorSticky <= 1'b0;
        end else begin
            launch <= launchRequest;
            if (launchRequest) begin
                setup.direction <= writeData[1:0];
                errorSticky <= 1'b0;
            end else if (errorPulse) begin
                errorSticky <= 1'b1;
            end
            if (regWrite) begin
                case (regSelect)
                    ramDmaPkg::busStartAddress:
                        setup.busStart <= writeData;
                    ramDmaPkg::memoryStartAddress:
                        setup.memoryStart <= writeData[ramDmaPkg::sramAddrWidth-1:0];
                    ramDmaPkg::blockSize:
                        setup.blockSize <= writeData[ramDmaPkg::blockSizeWidth-1:0];
                    ramDmaPkg::burstSize:
                        setup.burstSize <= writeData[ramDmaPkg::burstSizeWidth-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Register readback, sampled at the request edge
    always_ff @(posedge clock) begin
        case (regSelect)
            ramDmaPkg::busStartAddress:
                readData <= setup.busStart;
            ramDmaPkg::memoryStartAddress:
                readData <= {{(32 - ramDmaPkg::sramAddrWidth){1'b0}}, setup.memoryStart};
            ramDmaPkg::blockSize:
                readData <= {{(32 - ramDmaPkg::blockSizeWidth){1'b0}}, setup.blockSize};
            ramDmaPkg::burstSize:
                readData <= {{(32 - ramDmaPkg::burstSizeWidth){1'b0}}, setup.burstSize};
            ramDmaPkg::controlStatus:
                readData <= {30'd0, errorSticky, running | launch};
            default:
                readData <= 32'd0;
        endcase
    end

    dmaBusMaster busMaster (
        .clock          (clock),
        .reset          (reset),
        .setup          (setup),
        .launch         (launch),
        .busIn          (busIn),
        .busOut         (busOut),
        .sramAddress    (sramAddress),
        .sramWriteEnable(sramWriteEnable),
        .sramWriteData  (sramWriteData),
        .sramReadData   (sramReadData),
        .running        (running),
        .errorPulse     (errorPulse)
    );

endmodule

//--- source/dmaBusMaster.sv
/*
 * Bus master of the DMA engine.
 * Splits a block into bursts of at most burstSize+1 words and runs
 * each one on the system bus: request until grant, begin transaction,
 * data beats, end. Bus inputs arrive already registered by the top.
 */
`timescale 1ns/10ps

module dmaBusMaster (
    input  logic                                clock,
    input  logic                                reset,
    input  ramDmaPkg::dmaConfig                 setup,
    input  logic                                launch,
    input  ramDmaPkg::busToMaster               busIn,
    output ramDmaPkg::masterToBus               busOut,
    output logic [ramDmaPkg::sramAddrWidth-1:0] sramAddress,
    output logic                                sramWriteEnable,
    output logic [31:0]                         sramWriteData,
    input  logic [31:0]                         sramReadData,
    output logic                                running,
    output logic                                errorPulse
);

    ramDmaPkg::masterState state;
    logic [ramDmaPkg::blockSizeWidth-1:0] remaining;
    logic [ramDmaPkg::blockSizeWidth-1:0] remainingNext;
    logic [31:0] busAddress;
    logic [ramDmaPkg::sramAddrWidth-1:0] memoryAddress;
    logic [ramDmaPkg::burstSizeWidth:0] beatsLeft;
    logic [ramDmaPkg::burstSizeWidth:0] burstLength;
    logic [ramDmaPkg::burstSizeWidth:0] thisBurst;
    logic [ramDmaPkg::burstSizeWidth-1:0] burstCode;
    logic requestGap;
    logic inBurst;
    logic readBeat;
    logic writeAdvance;
    logic consume;

    assign inBurst = (state != ramDmaPkg::idle) && (state != ramDmaPkg::finish);
    assign running = (state != ramDmaPkg::idle);
    assign errorPulse = inBurst && busIn.error;

    // Last burst only carries what is left of the block
    assign burstLength = {1'b0, setup.burstSize} + 1'b1;
    assign thisBurst = (remaining < {1'b0, burstLength})
                       ? remaining[ramDmaPkg::burstSizeWidth:0] : burstLength;
    assign burstCode = thisBurst[ramDmaPkg::burstSizeWidth-1:0] - 1'b1;

    // Extra read beats beyond the burst are not stored
    assign readBeat = (state == ramDmaPkg::readBeats) && busIn.dataValid && (beatsLeft != '0);
    // Write beat goes through on a cycle without busy
    assign writeAdvance = (state == ramDmaPkg::writeBeats) && !busIn.busy;
    assign consume = readBeat || writeAdvance;
    assign remainingNext = remaining - consume;

    // Port B, read data lands one cycle after the address
    assign sramWriteEnable = readBeat;
    assign sramWriteData = busIn.addressData;
    assign sramAddress = writeAdvance ? memoryAddress + 1'b1 : memoryAddress;

    always_comb begin
        busOut = '0;
        busOut.request = inBurst && !requestGap;
        case (state)
            ramDmaPkg::beginRead, ramDmaPkg::beginWrite: begin
                busOut.beginTransaction = 1'b1;
                busOut.addressData = busAddress;
                busOut.burstSize = burstCode;
                busOut.byteEnable = 4'hF;
                busOut.readNotWrite = (state == ramDmaPkg::beginRead);
            end
            ramDmaPkg::writeBeats: begin
                busOut.dataValid = 1'b1;
                busOut.addressData = sramReadData;
            end
            ramDmaPkg::endWrite: begin
                busOut.endTransaction = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ramDmaPkg::idle;
            requestGap <= 1'b0;
        end else begin
            case (state)
                ramDmaPkg::idle: begin
                    if (launch) begin
                        remaining <= setup.blockSize;
                        busAddress <= setup.busStart;
                        memoryAddress <= setup.memoryStart;
                        requestGap <= 1'b0;
                        state <= (setup.blockSize == '0) ? ramDmaPkg::finish
                                                         : ramDmaPkg::request;
                    end
                end
                ramDmaPkg::request: begin
                    // Grant comes as a single pulse per request
                    if (requestGap) begin
                        requestGap <= 1'b0;
                    end else if (busIn.grant) begin
                        state <= setup.direction[0] ? ramDmaPkg::beginRead
                                                    : ramDmaPkg::beginWrite;
                    end
                end
                ramDmaPkg::beginRead: begin
                    beatsLeft <= thisBurst;
                    state <= ramDmaPkg::readBeats;
                end
                ramDmaPkg::readBeats: begin
                    if (busIn.endTransaction) begin
                        requestGap <= 1'b1;
                        state <= (remainingNext == '0) ? ramDmaPkg::finish
                                                       : ramDmaPkg::request;
                    end
                end
                ramDmaPkg::beginWrite: begin
                    beatsLeft <= thisBurst;
                    state <= ramDmaPkg::writeBeats;
                end
                ramDmaPkg::writeBeats: begin
                    if (writeAdvance && (beatsLeft == 1)) begin
                        state <= ramDmaPkg::endWrite;
                    end
                end
                ramDmaPkg::endWrite: begin
                    requestGap <= 1'b1;
                    state <= (remaining == '0) ? ramDmaPkg::finish : ramDmaPkg::request;
                end
                default: begin
                    state <= ramDmaPkg::idle;
                end
            endcase

            if (consume) begin
                memoryAddress <= memoryAddress + 1'b1;
                busAddress <= busAddress + 32'd4;
                remaining <= remainingNext;
                beatsLeft <= beatsLeft - 1'b1;
            end

            // Bus error aborts whatever is in flight
            if (errorPulse) begin
                state <= ramDmaPkg::finish;
            end
        end
    end

endmodule

//--- source/dualPortSsram.sv
/*
 * Local SRAM of the DMA block, 512 words of 32 bits.
 * Two independent ports on the same clock; each writes on the rising
 * edge when enabled and returns its registered read one cycle later.
 */
`timescale 1ns/10ps

module dualPortSsram (
    input  logic                                clock,
    input  logic [ramDmaPkg::sramAddrWidth-1:0] addressA,
    input  logic [ramDmaPkg::sramAddrWidth-1:0] addressB,
    input  logic                                writeEnableA,
    input  logic                                writeEnableB,
    input  logic [31:0]                         dataInA,
    input  logic [31:0]                         dataInB,
    output logic [31:0]                         dataOutA,
    output logic [31:0]                         dataOutB
);

    logic [31:0] memory [0:ramDmaPkg::sramDepth-1];

    // Port B wins when both ports write the same word
    always_ff @(posedge clock) begin
        if (writeEnableA) begin
            memory[addressA] <= dataInA;
        end
        if (writeEnableB) begin
            memory[addressB] <= dataInB;
        end
        // Read returns the old word on a same-cycle write
        dataOutA <= memory[addressA];
        dataOutB <= memory[addressB];
    end

endmodule

//--- source/ramDmaPkg.sv
/*
 * Shared definitions for the custom-instruction DMA block.
 * Holds the sizes, the register select and bus-master state
 * encodings, and the packed structs for the CPU port, the system
 * bus and the DMA setup.
 */
package ramDmaPkg;

    // Instruction number answered by this block
    localparam logic [7:0] customId = 8'h0D;

    localparam int sramDepth = 512;
    localparam int sramAddrWidth = 9;
    localparam int blockSizeWidth = 10;
    // Burst size is kept as beats minus one
    localparam int burstSizeWidth = 8;

    // Register select, valueA[12:10]
    typedef enum logic [2:0] {
        sramAccess         = 3'd0,
        busStartAddress    = 3'd1,
        memoryStartAddress = 3'd2,
        blockSize          = 3'd3,
        burstSize          = 3'd4,
        controlStatus      = 3'd5
    } regSelect;

    typedef enum logic [2:0] {
        idle,
        request,
        beginRead,
        readBeats,
        beginWrite,
        writeBeats,
        endWrite,
        finish
    } masterState;

    typedef struct packed {
        logic        start;
        logic [7:0]  ciN;
        logic [31:0] valueA;
        logic [31:0] valueB;
    } ciRequest;

    typedef struct packed {
        logic        grant;
        logic [31:0] addressData;
        logic        endTransaction;
        logic        dataValid;
        logic        busy;
        logic        error;
    } busToMaster;

    typedef struct packed {
        logic                      request;
        logic [31:0]               addressData;
        logic [burstSizeWidth-1:0] burstSize;
        logic [3:0]                byteEnable;
        logic                      readNotWrite;
        logic                      beginTransaction;
        logic                      endTransaction;
        logic                      dataValid;
    } masterToBus;

    // direction bit 0 is bus to SRAM, bit 1 is SRAM to bus
    typedef struct packed {
        logic [31:0]               busStart;
        logic [sramAddrWidth-1:0]  memoryStart;
        logic [blockSizeWidth-1:0] blockSize;
        logic [burstSizeWidth-1:0] burstSize;
        logic [1:0]                direction;
    } dmaConfig;

endpackage
